//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_rv32i_core
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
logic/rv32i_types.sv
logic/control_rom.sv
logic/regfile.sv
logic/exec_unit.sv
logic/datapath.sv
logic/rv32i_core.sv
verif/rv32i_checker.sv
verif/tb_rv32i_core.sv

//--- logic/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  rv32i_types::rv32i_word         instruction,
    output rv32i_types::rv32i_control_word ctrl
);

    import rv32i_types::*;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    assign opcode = rv32i_opcode'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb
    begin
        // Fields and immediates pass straight through.
        ctrl.opcode = opcode;
        ctrl.funct3 = funct3;
        ctrl.funct7 = funct7;
        ctrl.i_imm  = {{21{instruction[31]}}, instruction[30:20]};
        ctrl.s_imm  = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
        ctrl.b_imm  = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
        ctrl.u_imm  = {instruction[31:12], 12'h000};
        ctrl.j_imm  = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
        ctrl.rs1    = instruction[19:15];
        ctrl.rs2    = instruction[24:20];
        ctrl.rd     = instruction[11:7];
        ctrl.ir_out = instruction;

        ctrl.alumux1_sel    = alumux1_rs1_out;
        ctrl.alumux2_sel    = alumux2_i_imm;
        ctrl.cmpmux_sel     = cmpmux_rs2_out;
        ctrl.pcmux_sel      = pcmux_pc_plus4;
        ctrl.regfilemux_sel = regfilemux_alu_out;
        ctrl.aluop          = alu_add;
        ctrl.cmpop          = branch_funct3_t'(funct3);
        ctrl.load_regfile   = 1'b0; // Only writeback opcodes enable it.
        ctrl.load_pc        = 1'b1;
        ctrl.data_read      = 1'b0;
        ctrl.data_write     = 1'b0;

        unique case (opcode)
            op_imm, op_reg:
            begin
                ctrl.load_regfile = 1'b1;
                if (opcode == op_reg)
                begin
                    ctrl.alumux2_sel = alumux2_rs2_out;
                end
                else
                begin
                    ctrl.cmpmux_sel = cmpmux_i_imm;
                end
                unique case (arith_funct3_t'(funct3))
                    add:
                        // SUB exists only in the register form.
                        if (opcode == op_reg && funct7[5])
                            ctrl.aluop = alu_sub;
                    sll:  ctrl.aluop = alu_sll;
                    slt:
                    begin
                        ctrl.cmpop = blt;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu:
                    begin
                        ctrl.cmpop = bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    axor: ctrl.aluop = alu_xor;
                    sr:   ctrl.aluop = funct7[5] ? alu_sra : alu_srl;
                    aor:  ctrl.aluop = alu_or;
                    aand: ctrl.aluop = alu_and;
                    default: ;
                endcase
            end
            op_lui:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux1_sel = alumux1_pc_out;
                ctrl.alumux2_sel = alumux2_u_imm;
            end
            op_load:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.data_read = 1'b1;
                unique case (load_funct3_t'(funct3))
                    lb:      ctrl.regfilemux_sel = regfilemux_lb;
                    lh:      ctrl.regfilemux_sel = regfilemux_lh;
                    lbu:     ctrl.regfilemux_sel = regfilemux_lbu;
                    lhu:     ctrl.regfilemux_sel = regfilemux_lhu;
                    default: ctrl.regfilemux_sel = regfilemux_lw;
                endcase
            end
            op_store:
            begin
                ctrl.alumux2_sel = alumux2_s_imm;
                ctrl.data_write = 1'b1;
            end
            op_br:
            begin
                ctrl.alumux1_sel = alumux1_pc_out; // Target is pc + b_imm.
                ctrl.alumux2_sel = alumux2_b_imm;
            end
            op_jal:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux1_sel = alumux1_pc_out;
                ctrl.alumux2_sel = alumux2_j_imm;
                ctrl.pcmux_sel = pcmux_alu_out;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_jalr:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.pcmux_sel = pcmux_alu_mod2;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            default: ; // Unsupported opcodes only advance the PC.
        endcase
    end

endmodule : control_rom

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire                            clk,
    input  wire                            rst,
    input  rv32i_types::rv32i_control_word ctrl,
    input  rv32i_types::rv32i_word         data_rdata,
    output rv32i_types::rv32i_word         instr_addr,
    output rv32i_types::rv32i_word         data_addr,
    output rv32i_types::rv32i_word         data_wdata,
    output logic [3:0]                     data_wmask,
    output logic                           data_read,
    output logic                           data_write
);

    import rv32i_types::*;

    rv32i_word  pc;
    rv32i_word  pc_plus4;
    rv32i_word  pc_next;
    rv32i_word  rs1_out;
    rv32i_word  rs2_out;
    rv32i_word  alumux1_out;
    rv32i_word  alumux2_out;
    rv32i_word  cmpmux_out;
    rv32i_word  alu_out;
    rv32i_word  regfile_in;
    logic       br_en;
    logic [1:0] offset;
    logic [7:0] rdata_byte;
    logic [15:0] rdata_half;

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= reset_pc;
        else if (ctrl.load_pc)
            pc <= pc_next;
    end

    assign pc_plus4   = pc + 32'd4;
    assign instr_addr = pc;

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (ctrl.load_regfile & ~rst),
        .src_a (ctrl.rs1),
        .src_b (ctrl.rs2),
        .dest  (ctrl.rd),
        .in    (regfile_in),
        .reg_a (rs1_out),
        .reg_b (rs2_out)
    );

    assign alumux1_out = (ctrl.alumux1_sel == alumux1_pc_out) ? pc : rs1_out;
    assign cmpmux_out  = (ctrl.cmpmux_sel == cmpmux_i_imm) ? ctrl.i_imm : rs2_out;

    always_comb
    begin
        unique case (ctrl.alumux2_sel)
            alumux2_u_imm:   alumux2_out = ctrl.u_imm;
            alumux2_b_imm:   alumux2_out = ctrl.b_imm;
            alumux2_s_imm:   alumux2_out = ctrl.s_imm;
            alumux2_j_imm:   alumux2_out = ctrl.j_imm;
            alumux2_rs2_out: alumux2_out = rs2_out;
            default:         alumux2_out = ctrl.i_imm;
        endcase
    end

    exec_unit u_exec_unit (
        .aluop   (ctrl.aluop),
        .a       (alumux1_out),
        .b       (alumux2_out),
        .cmp_a   (rs1_out),
        .cmp_b   (cmpmux_out),
        .cmpop   (ctrl.cmpop),
        .alu_out (alu_out),
        .br_en   (br_en)
    );

    always_comb
    begin
        unique case (ctrl.pcmux_sel)
            pcmux_alu_out:  pc_next = alu_out;
            pcmux_alu_mod2: pc_next = {alu_out[31:1], 1'b0}; // JALR clears bit 0.
            default:        pc_next = (ctrl.opcode == op_br && br_en) ? alu_out : pc_plus4;
        endcase
    end

    assign offset     = alu_out[1:0];
    assign data_addr  = {alu_out[31:2], 2'b00};
    assign data_read  = ctrl.data_read & ~rst;
    assign data_write = ctrl.data_write & ~rst;

    // Store data moves into the addressed lanes.
    always_comb
    begin
        unique case (store_funct3_t'(ctrl.funct3))
            sb:
            begin
                data_wmask = 4'b0001 << offset;
                data_wdata = rs2_out << {offset, 3'b000};
            end
            sh:
            begin
                data_wmask = 4'b0011 << {offset[1], 1'b0};
                data_wdata = rs2_out << {offset[1], 4'b0000};
            end
            default:
            begin
                data_wmask = 4'b1111;
                data_wdata = rs2_out;
            end
        endcase
    end

    assign rdata_byte = data_rdata[{offset, 3'b000} +: 8];
    assign rdata_half = data_rdata[{offset[1], 4'b0000} +: 16];

    always_comb
    begin
        unique case (ctrl.regfilemux_sel)
            regfilemux_br_en:    regfile_in = {31'd0, br_en};
            regfilemux_u_imm:    regfile_in = ctrl.u_imm;
            regfilemux_lw:       regfile_in = data_rdata;
            regfilemux_pc_plus4: regfile_in = pc_plus4; // Link value.
            regfilemux_lb:       regfile_in = {{24{rdata_byte[7]}}, rdata_byte};
            regfilemux_lbu:      regfile_in = {24'd0, rdata_byte};
            regfilemux_lh:       regfile_in = {{16{rdata_half[15]}}, rdata_half};
            regfilemux_lhu:      regfile_in = {16'd0, rdata_half};
            default:             regfile_in = alu_out;
        endcase
    end

endmodule : datapath

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv32i_types::alu_ops         aluop,
    input  rv32i_types::rv32i_word      a,
    input  rv32i_types::rv32i_word      b,
    input  rv32i_types::rv32i_word      cmp_a,
    input  rv32i_types::rv32i_word      cmp_b,
    input  rv32i_types::branch_funct3_t cmpop,
    output rv32i_types::rv32i_word      alu_out,
    output logic                        br_en
);

    import rv32i_types::*;

    always_comb
    begin
        unique case (aluop)
            alu_add: alu_out = a + b;
            alu_sub: alu_out = a - b;
            alu_sll: alu_out = a << b[4:0];
            alu_srl: alu_out = a >> b[4:0];
            alu_sra: alu_out = rv32i_word'($signed(a) >>> b[4:0]);
            alu_xor: alu_out = a ^ b;
            alu_or:  alu_out = a | b;
            alu_and: alu_out = a & b;
            default: alu_out = a + b;
        endcase
    end

    // Shared by branches and set-less-than.
    always_comb
    begin
        unique case (cmpop)
            beq:     br_en = (cmp_a == cmp_b);
            bne:     br_en = (cmp_a != cmp_b);
            blt:     br_en = ($signed(cmp_a) < $signed(cmp_b));
            bge:     br_en = ($signed(cmp_a) >= $signed(cmp_b));
            bltu:    br_en = (cmp_a < cmp_b);
            bgeu:    br_en = (cmp_a >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

endmodule : exec_unit

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    load,
    input  rv32i_types::rv32i_reg  src_a,
    input  rv32i_types::rv32i_reg  src_b,
    input  rv32i_types::rv32i_reg  dest,
    input  rv32i_types::rv32i_word in,
    output rv32i_types::rv32i_word reg_a,
    output rv32i_types::rv32i_word reg_b
);

    import rv32i_types::*;

    rv32i_word regs [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (load && dest != 5'd0)
            regs[dest] <= in; // x0 writes are dropped.
    end

    assign reg_a = (src_a == 5'd0) ? '0 : regs[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 : regs[src_b];

endmodule : regfile

`default_nettype wire

//--- logic/rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core (
    input  wire                    clk,
    input  wire                    rst,
    output rv32i_types::rv32i_word instr_addr,
    input  rv32i_types::rv32i_word instruction,
    output rv32i_types::rv32i_word data_addr,
    output rv32i_types::rv32i_word data_wdata,
    output logic [3:0]             data_wmask,
    output logic                   data_read,
    output logic                   data_write,
    input  rv32i_types::rv32i_word data_rdata
);

    import rv32i_types::*;

    rv32i_control_word ctrl;

    control_rom u_control_rom (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .data_rdata (data_rdata),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_wmask (data_wmask),
        .data_read  (data_read),
        .data_write (data_write)
    );

endmodule : rv32i_core

`default_nettype wire

//--- logic/rv32i_types.sv
`default_nettype none

package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    localparam rv32i_word reset_pc = 32'h0000_0000; // First fetch after reset.

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011  // Decoded but not executed.
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000, // Also SUB when funct7 bit 5 is set.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // Logical or arithmetic by funct7 bit 5.
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // Low three bits follow funct3; bit 3 marks the funct7 variants.
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_ops;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'd0, // Branch target taken here when br_en is set.
        pcmux_alu_out  = 2'd1,
        pcmux_alu_mod2 = 2'd2
    } pcmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out  = 4'd0,
        regfilemux_br_en    = 4'd1,
        regfilemux_u_imm    = 4'd2,
        regfilemux_lw       = 4'd3,
        regfilemux_pc_plus4 = 4'd4,
        regfilemux_lb       = 4'd5,
        regfilemux_lbu      = 4'd6,
        regfilemux_lh       = 4'd7,
        regfilemux_lhu      = 4'd8
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        rv32i_word       i_imm;
        rv32i_word       s_imm;
        rv32i_word       b_imm;
        rv32i_word       u_imm;
        rv32i_word       j_imm;
        rv32i_reg        rs1;
        rv32i_reg        rs2;
        rv32i_reg        rd;
        rv32i_word       ir_out;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        pcmux_sel_t      pcmux_sel;
        regfilemux_sel_t regfilemux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic            load_regfile;
        logic            load_pc;
        logic            data_read;
        logic            data_write;
    } rv32i_control_word;

endpackage : rv32i_types

`default_nettype wire

//--- verif/rv32i_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_checker (
    input  wire                    clk,
    input  wire                    rst,
    input  rv32i_types::rv32i_word instr_addr,
    input  rv32i_types::rv32i_word instruction,
    input  rv32i_types::rv32i_word data_addr,
    input  rv32i_types::rv32i_word data_wdata,
    input  wire [3:0]              data_wmask,
    input  wire                    data_read,
    input  wire                    data_write,
    input  logic [7:0]             init_image [256],
    output logic [31:0]            error_count,
    output logic [31:0]            check_count
);

    import rv32i_types::*;

    rv32i_word  pc_m;
    rv32i_word  regs_m [32];
    logic [7:0] mem_m [256];
    int         errors = 0;
    int         checks = 0;

    assign error_count = 32'(errors);
    assign check_count = 32'(checks);

    task automatic compare(input string field, input rv32i_word got, input rv32i_word exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, field, got, exp);
        end
    endtask

    function automatic rv32i_word alu(input logic [2:0] f3, input logic alt,
                                      input rv32i_word a, input rv32i_word b);
        case (f3)
            3'b000: alu = alt ? a - b : a + b;
            3'b001: alu = a << b[4:0];
            3'b010: alu = {31'd0, $signed(a) < $signed(b)};
            3'b011: alu = {31'd0, a < b};
            3'b100: alu = a ^ b;
            3'b101:
                if (alt)
                    alu = rv32i_word'($signed(a) >>> b[4:0]);
                else
                    alu = a >> b[4:0];
            3'b110: alu = a | b;
            default: alu = a & b;
        endcase
    endfunction

    function automatic rv32i_word load_value(input logic [2:0] f3, input rv32i_word ea);
        logic [7:0]  lo;
        logic [15:0] half;
        lo   = mem_m[ea[7:0]];
        half = {mem_m[ea[7:0] + 8'd1], lo}; // Little endian.
        case (f3)
            3'b000: load_value = {{24{lo[7]}}, lo};
            3'b001: load_value = {{16{half[15]}}, half};
            3'b100: load_value = {24'd0, lo};
            3'b101: load_value = {16'd0, half};
            default: load_value = {mem_m[ea[7:0] + 8'd3], mem_m[ea[7:0] + 8'd2], half};
        endcase
    endfunction

    task automatic check_store(input logic [2:0] f3, input rv32i_word ea, input rv32i_word val);
        logic [3:0] mask;
        rv32i_word  lanes;
        rv32i_word  bits;
        case (f3)
            3'b000:  mask = 4'b0001 << ea[1:0];
            3'b001:  mask = 4'b0011 << ea[1:0];
            default: mask = 4'b1111;
        endcase
        lanes = val << (8 * ea[1:0]);
        bits  = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        compare("store data_addr", data_addr, {ea[31:2], 2'b00});
        compare("data_wmask", {28'd0, data_wmask}, {28'd0, mask});
        compare("data_wdata", data_wdata & bits, lanes & bits);
        for (int i = 0; i < 4; i++)
            if (mask[i])
                mem_m[{ea[7:2], 2'(i)}] = lanes[8 * i +: 8];
    endtask

    always @(posedge clk)
    begin : step
        logic [6:0] op;
        logic [2:0] f3;
        logic [4:0] rd;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  ii;
        rv32i_word  ea;
        rv32i_word  wb;
        rv32i_word  next_pc;
        logic       write_rd;
        logic       taken;
        if (rst)
        begin
            pc_m = reset_pc;
            for (int r = 0; r < 32; r++)
                regs_m[r] = '0;
            mem_m = init_image;
            compare("data_write during reset", {31'd0, data_write}, 32'd0);
        end
        else
        begin
            op = instruction[6:0];
            f3 = instruction[14:12];
            rd = instruction[11:7];
            a  = regs_m[instruction[19:15]];
            b  = regs_m[instruction[24:20]];
            ii = {{20{instruction[31]}}, instruction[31:20]};
            ea = a + ii;
            wb = '0;
            write_rd = 1'b0;
            next_pc  = pc_m + 32'd4;
            compare("instr_addr", instr_addr, pc_m);
            compare("data_read", {31'd0, data_read}, {31'd0, op == op_load});
            compare("data_write", {31'd0, data_write}, {31'd0, op == op_store});
            case (op)
                op_lui:
                begin
                    wb = {instruction[31:12], 12'h000};
                    write_rd = 1'b1;
                end
                op_auipc:
                begin
                    wb = pc_m + {instruction[31:12], 12'h000};
                    write_rd = 1'b1;
                end
                op_jal:
                begin
                    wb = pc_m + 32'd4;
                    write_rd = 1'b1;
                    next_pc = pc_m + {{12{instruction[31]}}, instruction[19:12],
                                      instruction[20], instruction[30:21], 1'b0};
                end
                op_jalr:
                begin
                    wb = pc_m + 32'd4;
                    write_rd = 1'b1;
                    next_pc = ea & ~32'd1;
                end
                op_br:
                begin
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        3'b111:  taken = (a >= b);
                        default: taken = 1'b0;
                    endcase
                    if (taken)
                        next_pc = pc_m + {{20{instruction[31]}}, instruction[7],
                                          instruction[30:25], instruction[11:8], 1'b0};
                end
                op_load:
                begin
                    compare("load data_addr", data_addr, {ea[31:2], 2'b00});
                    wb = load_value(f3, ea);
                    write_rd = 1'b1;
                end
                op_store:
                begin
                    ea = a + {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
                    check_store(f3, ea, b);
                end
                op_imm:
                begin
                    wb = alu(f3, instruction[30] & (f3 == 3'b101), a, ii); // No SUBI.
                    write_rd = 1'b1;
                end
                op_reg:
                begin
                    wb = alu(f3, instruction[30], a, b);
                    write_rd = 1'b1;
                end
                default: ;
            endcase
            if (write_rd && rd != 5'd0)
                regs_m[rd] = wb;
            pc_m = next_pc;
        end
    end

endmodule : rv32i_checker

`default_nettype wire

//--- verif/tb_rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_core;

    import rv32i_types::*;

    localparam int n_alu    = 2000;
    localparam int n_load   = 400;
    localparam int n_store  = 300;
    localparam int n_branch = 400;
    localparam int n_upper  = 200;
    localparam int n_dump   = 7;
    // Reset, the reset test, the five random tests, three register dumps and slack.
    localparam int max_cycles = 8 + 1 + n_alu + n_load + n_store + n_branch + n_upper
                                + 3 * n_dump + 100;

    localparam int k_alu    = 0;
    localparam int k_load   = 1;
    localparam int k_store  = 2;
    localparam int k_branch = 3;
    localparam int k_jal    = 4;
    localparam int k_jalr   = 5;
    localparam int k_lui    = 6;
    localparam int k_auipc  = 7;

    logic        clk = 1'b0;
    logic        rst;
    rv32i_word   instr_addr;
    rv32i_word   instruction;
    rv32i_word   data_addr;
    rv32i_word   data_wdata;
    logic [3:0]  data_wmask;
    logic        data_read;
    logic        data_write;
    rv32i_word   data_rdata;
    logic [7:0]  data_mem [256];
    logic [7:0]  init_image [256];
    logic [31:0] error_count;
    logic [31:0] check_count;
    integer      seed;
    int          cycles = 0;
    int          tests_done;

    rv32i_core u_rv32i_core (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instruction (instruction),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_wmask  (data_wmask),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_rdata  (data_rdata)
    );

    rv32i_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instruction (instruction),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_wmask  (data_wmask),
        .data_read   (data_read),
        .data_write  (data_write),
        .init_image  (init_image),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    assign data_rdata = {data_mem[{data_addr[7:2], 2'd3}], data_mem[{data_addr[7:2], 2'd2}],
                         data_mem[{data_addr[7:2], 2'd1}], data_mem[{data_addr[7:2], 2'd0}]};

    always @(posedge clk)
    begin
        if (rst)
            data_mem <= init_image; // Image reloads while reset is held.
        else if (data_write)
        begin
            for (int i = 0; i < 4; i++)
                if (data_wmask[i])
                    data_mem[{data_addr[7:2], 2'(i)}] <= data_wdata[8 * i +: 8];
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rnd(input int unsigned n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic rv32i_word make_instr(input int kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [20:0] off;
        rv32i_word   ir;
        rd  = 5'(rnd(8)); // Only x0 to x7, so values get reused.
        rs1 = 5'(rnd(8));
        rs2 = 5'(rnd(8));
        f3  = 3'(rnd(8));
        imm = 12'(rnd(4096));
        off = 21'(rnd(256) * 4) - 21'd512;
        ir  = 32'h0000_0013;
        case (kind)
            k_alu:
                if (rnd(2) == 0)
                begin
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm[11:5] = (f3 == 3'b101 && rnd(2) == 0) ? 7'h20 : 7'h00;
                    ir = {imm, rs1, f3, rd, op_imm};
                end
                else
                    ir = {((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 0) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd, op_reg};
            k_load:
            begin
                f3 = 3'(rnd(3));
                if (f3 != 3'b010 && rnd(2) == 0)
                    f3[2] = 1'b1; // Unsigned flavours.
                imm = 12'(rnd(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
                ir = {imm, 5'd0, f3, rd, op_load};
            end
            k_store:
            begin
                f3 = 3'(rnd(3));
                imm = 12'(rnd(256)) & ~((12'd1 << f3[1:0]) - 12'd1);
                ir = {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};
            end
            k_branch:
            begin
                f3 = 3'(rnd(6));
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;
                ir = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
            end
            k_jal:   ir = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
            k_jalr:
            begin
                imm = 12'(rnd(256) * 4 + rnd(2)); // Odd targets exercise the bit 0 clear.
                ir = {imm, 5'd0, 3'b000, rd, op_jalr};
            end
            k_lui:   ir = {20'(rnd(32'h10_0000)), rd, op_lui};
            k_auipc: ir = {20'(rnd(32'h10_0000)), rd, op_auipc};
            default: ;
        endcase
        return ir;
    endfunction

    function automatic int pick_kind(input int id);
        int unsigned r;
        r = rnd(20);
        case (id)
            2: pick_kind = (r < 2) ? k_lui : k_alu;
            3: pick_kind = (r < 10) ? k_load : ((r < 15) ? k_alu : k_store);
            4: pick_kind = (r < 12) ? k_store : k_alu;
            5:
                if (r < 8)
                    pick_kind = k_branch;
                else if (r < 11)
                    pick_kind = k_jal;
                else if (r < 14)
                    pick_kind = k_jalr;
                else
                    pick_kind = (r < 17) ? k_store : k_alu;
            default: pick_kind = (r < 7) ? k_lui : ((r < 14) ? k_auipc : k_store);
        endcase
    endfunction

    task automatic issue(input rv32i_word ir);
        instruction = ir;
        @(negedge clk);
    endtask

    // sw xN, 4N(x0) for x1 to x7.
    task automatic store_regs();
        for (int r = 1; r <= n_dump; r++)
            issue({7'd0, 5'(r), 5'd0, 3'b010, 5'(4 * r), op_store});
    endtask

    task automatic run_test(input int id, input string name, input int count, input bit dump);
        logic [31:0] errs_before;
        errs_before = error_count;
        for (int i = 0; i < count; i++)
            issue(make_instr(pick_kind(id)));
        if (dump)
            store_regs();
        $display("test %0d %s: %0d errors", id, name, error_count - errs_before);
        tests_done++;
    endtask

    initial
    begin
        seed = 53457;
        rst = 1'b1;
        tests_done = 0;
        instruction = {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, op_store}; // Store held during reset.
        for (int i = 0; i < 256; i++)
            init_image[i] = 8'($random(seed));
        repeat (8) @(negedge clk);
        rst = 1'b0;
        issue(make_instr(k_alu));
        $display("test 1 reset: %0d errors", error_count);
        tests_done = 1;
        run_test(2, "alu", n_alu, 1'b1);
        run_test(3, "loads", n_load, 1'b1);
        run_test(4, "store lanes", n_store, 1'b0);
        run_test(5, "branches and jumps", n_branch, 1'b0);
        run_test(6, "upper immediates", n_upper, 1'b1);
        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests_done, check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule : tb_rv32i_core

`default_nettype wire
